// File: snes_cart_bus.f
+incdir+include
verilog/snes_bus_pkg.sv
verilog/snes_bus_sync.sv
verilog/snes_alive_monitor.sv
verilog/rom_mapper.sv
verilog/rom_arbiter.sv
verilog/cart_bus_drive.sv
verilog/snes_cart_top.sv
testbench/tb_snes_cart.sv

// File: run_sim.sh
#!/bin/sh
# compile with verilator and run, exit status is the test result
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -j 0 \
       --top-module tb_snes_cart \
       -f snes_cart_bus.f \
       -o tb_snes_cart \
  && ./obj_dir/tb_snes_cart \
  || { echo "simulation did not pass"; exit 1; }

// File: include/tb_snes_tasks.svh
`ifndef TB_SNES_TASKS_SVH
`define TB_SNES_TASKS_SVH

//////////////////////////////
// random source and reference model
//////////////////////////////

// galois lfsr stepped once per bit taken
function automatic logic [15:0] lfsr_next(logic [15:0] s);
  return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
endfunction

function automatic logic [23:0] get_bits(int n);
  logic [23:0] r;
  r = '0;
  for (int k = 0; k < n; k++) begin
    lfsr_q = lfsr_next(lfsr_q);
    r = {r[22:0], lfsr_q[0]};
  end
  return r;
endfunction

// preload pattern that every address bit takes part in
function automatic byte_t exp_byte(snes_addr_t a);
  return (a[7:0] + 8'h3C) ^ {a[12:8], a[15:13]} ^ a[23:16];
endfunction

function automatic byte_t expected_at(snes_addr_t m);
  return shadow.exists(m) ? shadow[m] : exp_byte(m);
endfunction

// cpu address to rom-space address
function automatic snes_addr_t map_addr(snes_addr_t a);
  if ((&a[22:20]) && !a[15]) begin
    return SAVERAM_BASE | ({5'b0, a[19:16], a[14:0]} & saveram_mask);
  end
  if (mapper == 3'd0) begin
    return {2'b00, a[21:0]} & rom_mask; // hirom
  end
  return {2'b00, a[22:16], a[14:0]} & rom_mask;
endfunction

function automatic snes_addr_t rom_addr_rand();
  snes_addr_t a;
  a = get_bits(24);
  a[15] = 1'b1; // upper half is rom in both mappers
  return a;
endfunction

function automatic snes_addr_t sram_addr_rand();
  snes_addr_t a;
  a = get_bits(24);
  a[22:20] = 3'b111;
  a[15] = 1'b0;
  return a;
endfunction

//////////////////////////////
// bus cycles
//////////////////////////////

// one cpu cycle of 6 clocks low and 6 high with strobes late in the high phase
task automatic snes_cycle(input snes_addr_t a, input bit wr, input byte_t wd);
  snes_addr_t m;
  byte_t exp;
  @(posedge CLK2);
  m = map_addr(a);
  exp = expected_at(m);
  snes_cpu_clk_in <= 1'b0;
  snes_addr_in <= a;
  snes_romsel_in <= ~(a[15] | a[22]);
  snes_read_in <= 1'b1;
  snes_write_in <= 1'b1;
  snes_drv_en <= 1'b0;
  repeat (6) @(posedge CLK2);
  snes_cpu_clk_in <= 1'b1;
  snes_read_in <= wr;
  snes_drv_en <= wr;
  snes_drv_val <= wd;
  repeat (3) @(posedge CLK2);
  snes_write_in <= ~wr; // write strobe well after the mcu slot
  repeat (2) @(posedge CLK2);
  @(negedge CLK2);
  if (wr) begin
    assert (rom_we == 1'b0) else report_mismatch("rom_we", int'(rom_we), 0);
    assert (rom_bhe == m[0]) else report_mismatch("rom_bhe", int'(rom_bhe), int'(m[0]));
    assert (rom_ble == !m[0]) else report_mismatch("rom_ble", int'(rom_ble), int'(!m[0]));
    assert (snes_databus_dir == 1'b0)
      else report_mismatch("snes_databus_dir", int'(snes_databus_dir), 0);
    shadow[m] = wd;
  end else begin
    assert (snes_data == exp) else report_mismatch("snes_data", int'(snes_data), int'(exp));
    assert (snes_databus_oe == 1'b0)
      else report_mismatch("snes_databus_oe", int'(snes_databus_oe), 0);
    assert (snes_databus_dir == 1'b1)
      else report_mismatch("snes_databus_dir", int'(snes_databus_dir), 1);
  end
endtask

task automatic snes_release();
  @(posedge CLK2);
  snes_read_in <= 1'b1;
  snes_write_in <= 1'b1;
  snes_drv_en <= 1'b0;
endtask

// one mcu byte access where a lat_exp of 0 leaves the latency open
task automatic mcu_access(input bit wr, input snes_addr_t a, input byte_t d,
                          input int lat_exp);
  int lat;
  byte_t exp;
  exp = expected_at(a);
  @(posedge CLK2);
  mcu_rrq <= ~wr;
  mcu_wrq <= wr;
  mcu_addr <= a;
  mcu_dout <= d;
  @(posedge CLK2);
  mcu_rrq <= 1'b0;
  mcu_wrq <= 1'b0;
  lat = 0;
  @(negedge CLK2);
  while (!mcu_rdy) begin
    if (lat > 40) begin
      report_failure("mcu_rdy did not return high after an mcu access");
    end
    @(posedge CLK2);
    lat++;
    @(negedge CLK2);
  end
  if (lat_exp != 0) begin
    assert (lat == lat_exp) else report_mismatch("mcu_rdy latency", lat, lat_exp);
  end
  if (wr) begin
    shadow[a] = d;
  end else begin
    assert (mcu_din == exp) else report_mismatch("mcu_din", int'(mcu_din), int'(exp));
  end
endtask

`endif

// File: testbench/tb_snes_cart.sv
`timescale 1ns/10ps

module tb_snes_cart;
  import snes_bus_pkg::*;

  localparam int WATCHDOG_CYCLES = 5 * 4000; // five tests

  logic       CLK2;
  logic       rst;
  snes_addr_t snes_addr_in;
  wire byte_t snes_data;
  logic       snes_read_in, snes_write_in, snes_romsel_in, snes_cpu_clk_in;
  logic       snes_databus_oe, snes_databus_dir;
  snes_addr_t rom_addr;
  wire rom_word_t rom_data;
  logic       rom_we, rom_bhe, rom_ble;
  logic       mcu_rrq, mcu_wrq;
  snes_addr_t mcu_addr;
  byte_t      mcu_dout, mcu_din;
  logic       mcu_rdy;
  mapper_t    mapper;
  snes_addr_t rom_mask, saveram_mask;

  logic        snes_drv_en;
  byte_t       snes_drv_val;
  logic [15:0] lfsr_q = 16'd42516;
  byte_t       shadow [snes_addr_t]; // bytes written during the run
  logic [15:0] rom_mem [65536];
  logic [15:0] rom_idx;

  snes_cart_top #(.dead_timeout(300)) u_dut (.*);

  task automatic report_mismatch(input string name, input int got, input int exp);
    $display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("Error at %0t ns: %s", $time, what);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  `include "tb_snes_tasks.svh"

  ////////////////////////////////
  // models
  ////////////////////////////////

  assign snes_data = snes_drv_en ? snes_drv_val : 'z; // console write data

  // word memory, rom space low half plus save ram at the top
  assign rom_idx = {rom_addr[23], rom_addr[15:1]};
  assign rom_data = (rom_we && !u_dut.u_drive.lane_drive) ? rom_mem[rom_idx] : 'z;

  always @(negedge CLK2) begin
    if (rom_we == 1'b0) begin
      if (rom_addr[0]) rom_mem[rom_idx][7:0] <= rom_data[7:0]; // odd on low lane
      else rom_mem[rom_idx][15:8] <= rom_data[15:8];
    end
  end

  initial begin
    snes_addr_t base;
    for (int i = 0; i < 65536; i++) begin
      base = {(i[15] ? 8'hE0 : 8'h00), i[14:0], 1'b0};
      rom_mem[16'(i)] = {exp_byte(base), exp_byte(base | 24'd1)};
    end
  end

  initial begin
    CLK2 = 1'b0;
    forever #50 CLK2 = ~CLK2;
  end

  initial begin
    #(WATCHDOG_CYCLES * 100);
    report_failure("watchdog expired before the tests finished");
  end

  ////////////////////////////////
  // checks
  ////////////////////////////////

  a_rdy_reset: assert property (@(posedge CLK2) $fell(rst) |-> mcu_rdy)
    else report_mismatch("mcu_rdy", int'($sampled(mcu_rdy)), 1);
  a_we_reset: assert property (@(posedge CLK2) $fell(rst) |-> rom_we)
    else report_mismatch("rom_we", int'($sampled(rom_we)), 1);
  a_oe_reset: assert property (@(posedge CLK2) $fell(rst) |-> snes_databus_oe)
    else report_mismatch("snes_databus_oe", int'($sampled(snes_databus_oe)), 1);

  a_rdy_drop: assert property (@(posedge CLK2) disable iff (rst)
    (mcu_rrq || mcu_wrq) |=> !mcu_rdy)
    else report_mismatch("mcu_rdy", int'($sampled(mcu_rdy)), 0);

  // snes write never lands inside an mcu slot
  a_we_clash: assert property (@(posedge CLK2) disable iff (rst)
    (u_dut.mcu_hit && !u_dut.snes_write) |-> rom_we)
    else report_mismatch("rom_we", int'($sampled(rom_we)), 1);

  ////////////////////////////////
  // stimulus
  ////////////////////////////////

  initial begin
    snes_addr_t sram [4];
    rst = 1'b1;
    snes_addr_in = '0;
    snes_read_in = 1'b1;
    snes_write_in = 1'b1;
    snes_romsel_in = 1'b1;
    snes_cpu_clk_in = 1'b0; // console starts dead
    snes_drv_en = 1'b0;
    snes_drv_val = '0;
    mcu_rrq = 1'b0;
    mcu_wrq = 1'b0;
    mcu_addr = '0;
    mcu_dout = '0;
    mapper = 3'd1;
    rom_mask = 24'h00FFFF;
    saveram_mask = 24'h000FFF;
    repeat (5) @(posedge CLK2);
    rst <= 1'b0;
    repeat (2) @(posedge CLK2);

    // mcu reads with the console dead, fixed latency
    for (int i = 0; i < 3; i++) mcu_access(1'b0, get_bits(16), 8'h00, 9);

    // rom reads, lorom then hirom
    for (int i = 0; i < 6; i++) snes_cycle(rom_addr_rand(), 1'b0, 8'h00);
    @(posedge CLK2);
    mapper <= 3'd0;
    for (int i = 0; i < 6; i++) snes_cycle(rom_addr_rand(), 1'b0, 8'h00);

    // save ram writes and read back
    for (int i = 0; i < 4; i++) begin
      sram[i] = sram_addr_rand();
      snes_cycle(sram[i], 1'b1, byte_t'(get_bits(8)));
    end
    for (int i = 0; i < 4; i++) snes_cycle(sram[i], 1'b0, 8'h00);

    // mcu traffic in free slots next to live console cycles
    fork
      for (int i = 0; i < 24; i++) begin
        if (i[0]) snes_cycle(sram_addr_rand(), 1'b1, byte_t'(get_bits(8)));
        else snes_cycle(rom_addr_rand(), 1'b0, 8'h00);
      end
      for (int j = 0; j < 4; j++) begin
        mcu_access(1'b1, snes_addr_t'(24'hE01000 + j * 5), byte_t'(8'h5A ^ j * 29), 0);
        mcu_access(1'b0, snes_addr_t'(24'hE01000 + j * 5), 8'h00, 0);
      end
    join
    snes_release();
    repeat (4) @(posedge CLK2);
    $display("PASS: all tests");
    $finish;
  end

endmodule

// File: verilog/snes_cart_top.sv
`timescale 1ns/10ps

module snes_cart_top #(
  parameter int dead_timeout = snes_bus_pkg::DEAD_TIMEOUT_DEFAULT
) (
  input  logic                     CLK2,
  input  logic                     rst,
  // snes side
  input  snes_bus_pkg::snes_addr_t snes_addr_in,
  inout  snes_bus_pkg::byte_t      snes_data,
  input  logic                     snes_read_in,
  input  logic                     snes_write_in,
  input  logic                     snes_romsel_in,
  input  logic                     snes_cpu_clk_in,
  output logic                     snes_databus_oe,
  output logic                     snes_databus_dir,
  // rom side
  output snes_bus_pkg::snes_addr_t rom_addr,
  inout  snes_bus_pkg::rom_word_t  rom_data,
  output logic                     rom_we,
  output logic                     rom_bhe,
  output logic                     rom_ble,
  // mcu side
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  snes_bus_pkg::snes_addr_t mcu_addr,
  input  snes_bus_pkg::byte_t      mcu_dout,
  output snes_bus_pkg::byte_t      mcu_din,
  output logic                     mcu_rdy,
  input  snes_bus_pkg::mapper_t    mapper,
  input  snes_bus_pkg::snes_addr_t rom_mask,
  input  snes_bus_pkg::snes_addr_t saveram_mask
);
  import snes_bus_pkg::*;

  snes_addr_t snes_addr;
  snes_addr_t mapped_addr;
  snes_addr_t req_addr;
  byte_t      snes_data_in;
  byte_t      rom_byte;
  logic       snes_read, snes_write, snes_romsel, snes_cpu_clk;
  logic       cpu_clk_raw, cycle_start, cycle_end;
  logic       snes_dead, revive;
  logic       rom_hit, is_rom, is_saveram, is_writable;
  logic       mcu_hit, mcu_we_hit, mcu_wr_hit;

  // read and write strobes are for register peripherals, none fitted here
  snes_bus_sync u_sync (
    .CLK2(CLK2), .rst(rst),
    .snes_addr_in(snes_addr_in), .snes_data_pad(snes_data),
    .snes_read_in(snes_read_in), .snes_write_in(snes_write_in),
    .snes_romsel_in(snes_romsel_in), .snes_cpu_clk_in(snes_cpu_clk_in),
    .snes_addr(snes_addr), .snes_data_in(snes_data_in),
    .snes_read(snes_read), .snes_write(snes_write),
    .snes_romsel(snes_romsel), .snes_cpu_clk(snes_cpu_clk),
    .cpu_clk_raw(cpu_clk_raw),
    .rd_start(), .rd_end(), .wr_end(),
    .cycle_start(cycle_start), .cycle_end(cycle_end)
  );

  snes_alive_monitor #(.dead_timeout(dead_timeout)) u_alive (
    .CLK2(CLK2), .rst(rst), .cpu_clk_raw(cpu_clk_raw),
    .snes_dead(snes_dead), .revive(revive)
  );

  rom_mapper u_mapper (
    .mapper(mapper), .snes_addr(snes_addr),
    .rom_mask(rom_mask), .saveram_mask(saveram_mask),
    .mapped_addr(mapped_addr), .rom_hit(rom_hit), .is_rom(is_rom),
    .is_saveram(is_saveram), .is_writable(is_writable)
  );

  rom_arbiter u_arbiter (
    .CLK2(CLK2), .rst(rst),
    .mcu_rrq(mcu_rrq), .mcu_wrq(mcu_wrq), .mcu_addr(mcu_addr),
    .cycle_start(cycle_start), .cycle_end(cycle_end), .rom_hit(rom_hit),
    .snes_dead(snes_dead), .revive(revive), .rom_byte(rom_byte),
    .mcu_rdy(mcu_rdy), .mcu_din(mcu_din), .req_addr(req_addr),
    .mcu_hit(mcu_hit), .mcu_we_hit(mcu_we_hit), .mcu_wr_hit(mcu_wr_hit)
  );

  cart_bus_drive u_drive (
    .mapped_addr(mapped_addr), .req_addr(req_addr),
    .mcu_hit(mcu_hit), .mcu_we_hit(mcu_we_hit), .mcu_wr_hit(mcu_wr_hit),
    .rom_hit(rom_hit), .is_rom(is_rom), .is_saveram(is_saveram),
    .is_writable(is_writable), .mcu_dout(mcu_dout),
    .snes_read(snes_read), .snes_write(snes_write),
    .snes_cpu_clk(snes_cpu_clk), .snes_romsel(snes_romsel),
    .snes_data_in(snes_data_in),
    .rom_addr(rom_addr), .rom_data(rom_data), .rom_we(rom_we),
    .rom_bhe(rom_bhe), .rom_ble(rom_ble), .rom_byte(rom_byte),
    .snes_data(snes_data), .snes_databus_oe(snes_databus_oe),
    .snes_databus_dir(snes_databus_dir)
  );

endmodule

// File: verilog/cart_bus_drive.sv
`timescale 1ns/10ps

module cart_bus_drive (
  input  snes_bus_pkg::snes_addr_t  mapped_addr,
  input  snes_bus_pkg::snes_addr_t  req_addr,
  input  logic                      mcu_hit,
  input  logic                      mcu_we_hit,
  input  logic                      mcu_wr_hit,
  input  logic                      rom_hit,
  input  logic                      is_rom,
  input  logic                      is_saveram,
  input  logic                      is_writable,
  input  snes_bus_pkg::byte_t       mcu_dout,
  input  logic                      snes_read,
  input  logic                      snes_write,
  input  logic                      snes_cpu_clk,
  input  logic                      snes_romsel,
  input  snes_bus_pkg::byte_t       snes_data_in,
  output snes_bus_pkg::snes_addr_t  rom_addr,
  inout  snes_bus_pkg::rom_word_t   rom_data,
  output logic                      rom_we,
  output logic                      rom_bhe,
  output logic                      rom_ble,
  output snes_bus_pkg::byte_t       rom_byte,
  inout  snes_bus_pkg::byte_t       snes_data,
  output logic                      snes_databus_oe,
  output logic                      snes_databus_dir
);
  import snes_bus_pkg::*;

  logic  lane_lo;
  logic  snes_wr_hit;
  logic  lane_drive;
  byte_t lane_out;
  logic  card_sel;

  assign rom_addr = mcu_hit ? req_addr : mapped_addr;
  assign lane_lo  = rom_addr[0]; // odd address sits on the low byte
  assign rom_bhe  = lane_lo;
  assign rom_ble  = ~lane_lo;

  //////////////////////////////
  // rom lane drive
  //////////////////////////////

  assign snes_wr_hit = rom_hit & ~snes_write;
  assign lane_drive  = snes_wr_hit | mcu_wr_hit;
  assign lane_out    = snes_wr_hit ? snes_data_in : mcu_dout;

  assign rom_data[7:0]  = (lane_drive & lane_lo) ? lane_out : 'z;
  assign rom_data[15:8] = (lane_drive & ~lane_lo) ? lane_out : 'z;

  always_comb begin
    if (rom_hit & is_writable & snes_cpu_clk) begin
      rom_we = snes_write;
    end else if (mcu_we_hit) begin
      rom_we = 1'b0;
    end else begin
      rom_we = 1'b1;
    end
  end

  assign rom_byte = lane_lo ? rom_data[7:0] : rom_data[15:8];

  //////////////////////////////
  // snes data bus
  //////////////////////////////

  assign snes_data = ~snes_read ? rom_byte : 'z;

  // buffer opens only for our own regions
  assign card_sel         = (is_rom & ~snes_romsel) | is_saveram;
  assign snes_databus_oe  = ~(card_sel & ~(snes_read & snes_write));
  assign snes_databus_dir = ~snes_read; // 1 drives toward the console

endmodule

// File: verilog/rom_arbiter.sv
`timescale 1ns/10ps

module rom_arbiter (
  input  logic                     CLK2,
  input  logic                     rst,
  input  logic                     mcu_rrq,
  input  logic                     mcu_wrq,
  input  snes_bus_pkg::snes_addr_t mcu_addr,
  input  logic                     cycle_start,
  input  logic                     cycle_end,
  input  logic                     rom_hit,
  input  logic                     snes_dead,
  input  logic                     revive,
  input  snes_bus_pkg::byte_t      rom_byte,
  output logic                     mcu_rdy,
  output snes_bus_pkg::byte_t      mcu_din,
  output snes_bus_pkg::snes_addr_t req_addr,
  output logic                     mcu_hit,
  output logic                     mcu_we_hit,
  output logic                     mcu_wr_hit
);
  import snes_bus_pkg::*;

  arb_state_t state;
  logic [3:0] delay_cnt;
  logic       rd_pend;
  logic       wr_pend;
  logic       free_strobe;
  logic       free_slot;
  logic       acc_done;

  //////////////////////////////
  // free slot detection
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      free_strobe <= 1'b0;
    end else begin
      free_strobe <= cycle_start & ~rom_hit; // cycle that leaves rom alone
    end
  end

  assign free_slot = cycle_end | free_strobe;
  assign acc_done  = (state == MCU_RD_END) | (state == MCU_WR_END);

  //////////////////////////////
  // request latch
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end else if (mcu_rrq) begin
      rd_pend <= 1'b1; // read wins over a write in the same cycle
      mcu_rdy <= 1'b0;
    end else if (mcu_wrq) begin
      wr_pend <= 1'b1;
      mcu_rdy <= 1'b0;
    end else if (acc_done) begin
      rd_pend <= 1'b0;
      wr_pend <= 1'b0;
      mcu_rdy <= 1'b1;
    end
  end

  always_ff @(posedge CLK2) begin
    if (mcu_rrq | mcu_wrq) begin
      req_addr <= mcu_addr;
    end
  end

  //////////////////////////////
  // access fsm
  //////////////////////////////

  always_ff @(posedge CLK2) begin
    if (rst) begin
      state     <= IDLE;
      delay_cnt <= '0;
    end else if (revive) begin
      state <= IDLE; // restarts later from the pending flag
    end else begin
      case (state)
        IDLE: begin
          if (free_slot | snes_dead) begin
            if (rd_pend) begin
              state     <= MCU_RD_ADDR;
              delay_cnt <= ROM_CYCLE_LEN;
            end else if (wr_pend) begin
              state     <= MCU_WR_ADDR;
              delay_cnt <= ROM_CYCLE_LEN;
            end
          end
        end
        MCU_RD_ADDR: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= MCU_RD_END;
        end
        MCU_WR_ADDR: begin
          delay_cnt <= delay_cnt - 1'b1;
          if (delay_cnt == '0) state <= MCU_WR_END;
        end
        default: state <= IDLE; // both end states
      endcase
    end
  end

  // last capture before the end state holds the settled byte
  always_ff @(posedge CLK2) begin
    if (state == MCU_RD_ADDR) begin
      mcu_din <= rom_byte;
    end
  end

  assign mcu_we_hit = (state == MCU_WR_ADDR);
  assign mcu_wr_hit = mcu_we_hit | (state == MCU_WR_END);
  assign mcu_hit    = (state != IDLE);

  a_req_backpressure: assert property (@(posedge CLK2) disable iff (rst)
    (mcu_rrq || mcu_wrq) |-> mcu_rdy)
    else $error("mcu request while mcu_rdy low");

  a_busy_not_ready: assert property (@(posedge CLK2) disable iff (rst)
    (state != IDLE) |-> !mcu_rdy)
    else $error("mcu_rdy high during an access");

endmodule

// File: verilog/rom_mapper.sv
`timescale 1ns/10ps

module rom_mapper (
  input  snes_bus_pkg::mapper_t    mapper,
  input  snes_bus_pkg::snes_addr_t snes_addr,
  input  snes_bus_pkg::snes_addr_t rom_mask,
  input  snes_bus_pkg::snes_addr_t saveram_mask,
  output snes_bus_pkg::snes_addr_t mapped_addr,
  output logic                     rom_hit,
  output logic                     is_rom,
  output logic                     is_saveram,
  output logic                     is_writable
);
  import snes_bus_pkg::*;

  logic       rom_sel;
  snes_addr_t rom_space;
  snes_addr_t sram_space;

  // lower half of banks $70-$7F and $F0-$FF
  assign is_saveram = (&snes_addr[22:20]) & ~snes_addr[15];
  assign sram_space = SAVERAM_BASE
                    | (snes_addr_t'({snes_addr[19:16], snes_addr[14:0]}) & saveram_mask);

  always_comb begin
    if (mapper == MAPPER_HIROM) begin
      rom_sel   = snes_addr[22] | snes_addr[15];
      rom_space = {2'b00, snes_addr[21:0]} & rom_mask;
    end else begin
      // lorom drops address bit 15
      rom_sel   = snes_addr[15];
      rom_space = {2'b00, snes_addr[22:16], snes_addr[14:0]} & rom_mask;
    end
  end

  assign is_rom      = rom_sel & ~is_saveram; // save ram decode wins
  assign is_writable = is_saveram;
  assign rom_hit     = is_rom | is_saveram;
  assign mapped_addr = is_saveram ? sram_space : rom_space;

endmodule

// File: verilog/snes_alive_monitor.sv
`timescale 1ns/10ps

module snes_alive_monitor #(
  parameter int dead_timeout = snes_bus_pkg::DEAD_TIMEOUT_DEFAULT
) (
  input  logic CLK2,
  input  logic rst,
  input  logic cpu_clk_raw,
  output logic snes_dead,
  output logic revive
);

  logic [$clog2(dead_timeout + 2)-1:0] low_cnt;

  // cycles spent with cpu clock low
  always_ff @(posedge CLK2) begin
    if (rst) begin
      low_cnt <= '0;
    end else if (cpu_clk_raw) begin
      low_cnt <= '0;
    end else if (int'(low_cnt) <= dead_timeout) begin
      low_cnt <= low_cnt + 1'b1; // holds one past the timeout
    end
  end

  always_ff @(posedge CLK2) begin
    if (rst) begin
      snes_dead <= 1'b1;
      revive    <= 1'b0;
    end else begin
      revive <= 1'b0;
      if (cpu_clk_raw) begin
        snes_dead <= 1'b0;
        revive    <= snes_dead; // first clock after being dead
      end else if (int'(low_cnt) > dead_timeout) begin
        snes_dead <= 1'b1;
      end
    end
  end

endmodule

// File: verilog/snes_bus_sync.sv
`timescale 1ns/10ps

module snes_bus_sync (
  input  logic                     CLK2,
  input  logic                     rst,
  input  snes_bus_pkg::snes_addr_t snes_addr_in,
  input  snes_bus_pkg::byte_t      snes_data_pad,
  input  logic                     snes_read_in,
  input  logic                     snes_write_in,
  input  logic                     snes_romsel_in,
  input  logic                     snes_cpu_clk_in,
  output snes_bus_pkg::snes_addr_t snes_addr,
  output snes_bus_pkg::byte_t      snes_data_in,
  output logic                     snes_read,
  output logic                     snes_write,
  output logic                     snes_romsel,
  output logic                     snes_cpu_clk,
  output logic                     cpu_clk_raw,
  output logic                     rd_start,
  output logic                     rd_end,
  output logic                     wr_end,
  output logic                     cycle_start,
  output logic                     cycle_end
);
  import snes_bus_pkg::*;

  hist_t      read_hist;
  hist_t      write_hist;
  hist_t      romsel_hist;
  hist_t      clk_hist;
  snes_addr_t addr_pipe [5];
  byte_t      data_pipe [4];

  always_ff @(posedge CLK2) begin
    if (rst) begin
      read_hist   <= '1; // idle bus
      write_hist  <= '1;
      romsel_hist <= '1;
      clk_hist    <= '0;
    end else begin
      read_hist   <= {read_hist[6:0], snes_read_in};
      write_hist  <= {write_hist[6:0], snes_write_in};
      romsel_hist <= {romsel_hist[6:0], snes_romsel_in};
      clk_hist    <= {clk_hist[6:0], snes_cpu_clk_in};
    end
  end

  // address and data settle slower than the strobes
  always_ff @(posedge CLK2) begin
    addr_pipe[0] <= snes_addr_in;
    data_pipe[0] <= snes_data_pad;
    for (int i = 1; i < 5; i++) begin
      addr_pipe[i] <= addr_pipe[i-1];
    end
    for (int i = 1; i < 4; i++) begin
      data_pipe[i] <= data_pipe[i-1];
    end
  end

  // bit 0 is the capture flop, bit 1 the first usable sample
  assign snes_read    = read_hist[2] & read_hist[1];
  assign snes_write   = write_hist[2] & write_hist[1];
  assign snes_cpu_clk = clk_hist[2] & clk_hist[1];
  assign cpu_clk_raw  = clk_hist[1];
  assign snes_romsel  = romsel_hist[4] & romsel_hist[3];
  assign snes_addr    = addr_pipe[4] & addr_pipe[3]; // valid five edges on
  assign snes_data_in = data_pipe[3] & data_pipe[2];

  assign rd_start    = (read_hist[6:1] == EDGE_FALL);
  assign rd_end      = (read_hist[6:1] == EDGE_RISE);
  assign wr_end      = (write_hist[6:1] == EDGE_RISE);
  assign cycle_start = (clk_hist[6:1] == EDGE_RISE);
  assign cycle_end   = (clk_hist[6:1] == EDGE_FALL);

  // console never opens a read in the middle of a write
  a_rd_in_wr: assert property (@(posedge CLK2) disable iff (rst)
    rd_start |-> snes_write)
    else $error("read strobe started while write line low");

endmodule

// File: verilog/snes_bus_pkg.sv
package snes_bus_pkg;

  //////////////////////////////
  // widths with a meaning
  //////////////////////////////

  typedef logic [23:0] snes_addr_t; // cpu address, also rom-space byte address
  typedef logic [7:0]  byte_t;
  typedef logic [15:0] rom_word_t;  // 16 bit rom bus
  typedef logic [2:0]  mapper_t;
  typedef logic [7:0]  hist_t;      // newest sample in bit 0

  //////////////////////////////
  // constants
  //////////////////////////////

  // any mapper value other than hirom decodes as lorom
  localparam mapper_t MAPPER_HIROM = 3'd0;

  // delay load for an mcu access, gives seven address cycles
  localparam logic [3:0] ROM_CYCLE_LEN = 4'd6;

  // cycles of cpu clock low before the console counts as dead
  localparam int DEAD_TIMEOUT_DEFAULT = 80000;

  localparam snes_addr_t SAVERAM_BASE = 24'hE00000;

  // strobe history patterns, old level for five samples then the new one
  localparam logic [5:0] EDGE_FALL = 6'b111110;
  localparam logic [5:0] EDGE_RISE = 6'b000001;

  //////////////////////////////
  // arbiter states
  //////////////////////////////

  typedef enum logic [2:0] {
    IDLE,
    MCU_RD_ADDR,
    MCU_RD_END,
    MCU_WR_ADDR,
    MCU_WR_END
  } arb_state_t;

endpackage
